// ==== Makefile ====
# Verilator build and run for the BIU to Wishbone bridge
VERILATOR ?= verilator
TOP       ?= tb_biu_wb
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== biu2wb_bridge.sv ====
//////////////////////////////////////////////////
// turns one biu strobe port of the core into wishbone
// b3 master cycles, one instance per core port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module biu2wb_bridge #(
  parameter int PLEN = 32
) (
  input  logic               HCLK,
  input  logic               HRESETn,

  // biu side, from the core
  input  logic               biu_stb_i,      // request, held until stb_ack
  output logic               biu_stb_ack_o,  // request taken
  output logic               biu_d_ack_o,    // write beat done, show next data
  input  logic [PLEN-1:0]    biu_adri_i,
  output logic [PLEN-1:0]    biu_adro_o,     // address of the acked beat
  input  biu_pkg::biu_size_t biu_size_i,
  input  biu_pkg::biu_type_t biu_type_i,
  input  logic               biu_we_i,
  input  biu_pkg::data_t     biu_d_i,
  output biu_pkg::data_t     biu_q_o,
  output logic               biu_ack_o,      // one pulse per beat
  output logic               biu_err_o,      // burst aborted

  // wishbone master side
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output logic [PLEN-1:0]    wb_adr_o,
  output biu_pkg::data_t     wb_dat_o,
  output biu_pkg::sel_t      wb_sel_o,
  output biu_pkg::cti_t      wb_cti_o,
  output biu_pkg::bte_t      wb_bte_o,
  input  biu_pkg::data_t     wb_dat_i,
  input  logic               wb_ack_i,
  input  logic               wb_err_i
);

  import biu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,   // waiting for a strobe
    BEAT,   // stb out, waiting for ack or err
    GAP     // stb low, next beat loading
  } state_t;

  state_t    state;
  beat_cnt_t beat_cnt;    // beats left after the current one
  biu_size_t size_q;      // size of the running burst
  logic      accept;
  logic      beat_done;
  logic      last_beat;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // lanes from size and the low address bits
  function automatic sel_t byte_sel(biu_size_t size, logic [1:0] lane);
    case (size)
      BIU_BYTE:  return sel_t'(4'b0001 << lane);
      BIU_HWORD: return lane[1] ? 4'b1100 : 4'b0011;
      BIU_WORD:  return 4'b1111;
      default:   return 4'b1111;
    endcase
  endfunction

  // next word address, wrap keeps the bits above the block
  function automatic logic [PLEN-1:0] next_addr(logic [PLEN-1:0] adr, bte_t bte);
    logic [PLEN-1:0] inc;
    inc = (adr + PLEN'(4)) & ~PLEN'(3);
    case (bte)
      BTE_WRAP4:  return {adr[PLEN-1:4], inc[3:0]};   // 16 byte block
      BTE_WRAP8:  return {adr[PLEN-1:5], inc[4:0]};   // 32 byte block
      BTE_WRAP16: return {adr[PLEN-1:6], inc[5:0]};   // 64 byte block
      default:    return inc;
    endcase
  endfunction

  function automatic bte_t wrap_bte(biu_type_t btype);
    if (!burst_wraps(btype)) return BTE_LINEAR;
    case (burst_beats(btype))
      4'd3:    return BTE_WRAP4;
      4'd7:    return BTE_WRAP8;
      default: return BTE_WRAP16;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  assign accept    = (state == IDLE) & biu_stb_i;
  assign beat_done = wb_stb_o & wb_ack_i & ~wb_err_i;  // err wins over ack
  assign last_beat = (beat_cnt == '0);

  assign wb_cyc_o = (state != IDLE);   // high over the whole burst
  assign wb_stb_o = (state == BEAT);

  assign biu_stb_ack_o = accept;
  assign biu_d_ack_o   = beat_done & wb_we_o;
  assign biu_ack_o     = beat_done;
  assign biu_err_o     = wb_stb_o & wb_err_i;
  assign biu_q_o       = wb_dat_i;    // read data straight through
  assign biu_adro_o    = wb_adr_o;

  //////////////////////////////////////////////////
  // beat sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state    <= IDLE;
      beat_cnt <= '0;
      wb_we_o  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (biu_stb_i) begin
            state    <= BEAT;
            beat_cnt <= burst_beats(biu_type_i);
            wb_we_o  <= biu_we_i;
          end
        end
        BEAT: begin
          if (wb_err_i) begin
            state    <= IDLE;     // abort, no more beats
            beat_cnt <= '0;
          end else if (wb_ack_i) begin
            if (last_beat) begin
              state <= IDLE;
            end else begin
              state    <= GAP;
              beat_cnt <= beat_cnt - 1'b1;
            end
          end
        end
        GAP:     state <= BEAT;   // one idle stb cycle
        default: state <= IDLE;
      endcase
    end
  end

  // address, data and qualifiers of the beat on the bus
  always_ff @(posedge HCLK) begin
    if (accept) begin
      wb_adr_o <= biu_adri_i;
      wb_dat_o <= biu_d_i;                  // beat 0 write data
      wb_sel_o <= byte_sel(biu_size_i, biu_adri_i[1:0]);
      wb_cti_o <= (burst_beats(biu_type_i) == '0) ? CTI_CLASSIC : CTI_INCR;
      wb_bte_o <= wrap_bte(biu_type_i);
      size_q   <= biu_size_i;
    end else if (state == GAP) begin
      wb_adr_o <= next_addr(wb_adr_o, wb_bte_o);
      wb_dat_o <= biu_d_i;                  // core moved on after d_ack
      wb_sel_o <= byte_sel(size_q, 2'b00);  // later beats are word aligned
      wb_cti_o <= last_beat ? CTI_END : CTI_INCR;
    end
  end

endmodule

// ==== biu_patterns.txt ====
// port (0 fetch, 1 load/store, 2 both), write, burst type, size, address, data seed
// port 2 runs the data side at address+100 with seed+100, f ends the list
1 1 0 0 00000101 11223344
1 0 0 0 00000100 00000000
1 1 0 1 00000112 55667788
1 0 0 1 00000110 00000000
1 1 1 2 00000120 9abcdef0
0 0 0 2 00000120 00000000
1 1 3 2 00000200 a0000000
0 0 3 2 00000200 00000000
1 1 5 2 00000300 b0000000
1 0 5 2 00000300 00000000
1 1 7 2 00000400 c0000000
0 0 7 2 00000400 00000000
1 1 2 2 00000508 d0000000
1 0 2 2 00000508 00000000
1 1 4 2 00000614 e0000000
0 0 6 2 00000728 00000000
2 0 3 2 00000200 00000000
2 1 2 2 00000808 f0000000
1 0 5 2 f0000040 00000000
1 0 0 2 00000120 00000000
0 1 3 2 fffffff0 12345678
0 0 3 2 00000200 00000000
f 0 0 0 00000000 00000000

// ==== biu_pkg.sv ====
//////////////////////////////////////////////////
// widths, bus codes and burst helpers shared by the
// biu bridges, the wishbone arbiter and the testbench
//////////////////////////////////////////////////
package biu_pkg;

  localparam int XLEN = 32;                // data path, fixed

  typedef logic [XLEN-1:0]   data_t;       // one bus word
  typedef logic [XLEN/8-1:0] sel_t;        // byte lanes
  typedef logic [2:0]        biu_type_t;
  typedef logic [2:0]        biu_size_t;
  typedef logic [2:0]        cti_t;
  typedef logic [1:0]        bte_t;
  typedef logic [3:0]        beat_cnt_t;   // beats left, length minus 1

  // biu burst types
  localparam biu_type_t BIU_SINGLE = 3'd0;
  localparam biu_type_t BIU_INCR   = 3'd1;  // runs as one beat
  localparam biu_type_t BIU_WRAP4  = 3'd2;
  localparam biu_type_t BIU_INCR4  = 3'd3;
  localparam biu_type_t BIU_WRAP8  = 3'd4;
  localparam biu_type_t BIU_INCR8  = 3'd5;
  localparam biu_type_t BIU_WRAP16 = 3'd6;
  localparam biu_type_t BIU_INCR16 = 3'd7;

  // transfer sizes
  localparam biu_size_t BIU_BYTE  = 3'd0;
  localparam biu_size_t BIU_HWORD = 3'd1;
  localparam biu_size_t BIU_WORD  = 3'd2;

  // wishbone b3 cycle type identifiers
  localparam cti_t CTI_CLASSIC = 3'b000;
  localparam cti_t CTI_INCR    = 3'b010;
  localparam cti_t CTI_END     = 3'b111;

  // burst type extension
  localparam bte_t BTE_LINEAR = 2'b00;
  localparam bte_t BTE_WRAP4  = 2'b01;
  localparam bte_t BTE_WRAP8  = 2'b10;
  localparam bte_t BTE_WRAP16 = 2'b11;

  // beat count minus 1 for a burst type
  function automatic beat_cnt_t burst_beats(biu_type_t btype);
    case (btype)
      BIU_SINGLE, BIU_INCR:   return 4'd0;
      BIU_WRAP4, BIU_INCR4:   return 4'd3;
      BIU_WRAP8, BIU_INCR8:   return 4'd7;
      BIU_WRAP16, BIU_INCR16: return 4'd15;
      default:                return 4'd0;
    endcase
  endfunction

  function automatic logic burst_wraps(biu_type_t btype);
    return btype inside {BIU_WRAP4, BIU_WRAP8, BIU_WRAP16};
  endfunction

endpackage

// ==== biu_wb_top.sv ====
//////////////////////////////////////////////////
// core bus interface: instruction and data bridges
// merged onto one external wishbone master port
//////////////////////////////////////////////////
`timescale 1ns/1ps

module biu_wb_top #(
  parameter int PLEN = 32
) (
  input  logic               HCLK,
  input  logic               HRESETn,

  // instruction fetch port
  input  logic               ibiu_stb_i,
  output logic               ibiu_stb_ack_o,
  output logic               ibiu_d_ack_o,
  input  logic [PLEN-1:0]    ibiu_adri_i,
  output logic [PLEN-1:0]    ibiu_adro_o,
  input  biu_pkg::biu_size_t ibiu_size_i,
  input  biu_pkg::biu_type_t ibiu_type_i,
  input  logic               ibiu_we_i,
  input  biu_pkg::data_t     ibiu_d_i,
  output biu_pkg::data_t     ibiu_q_o,
  output logic               ibiu_ack_o,
  output logic               ibiu_err_o,

  // load/store port
  input  logic               dbiu_stb_i,
  output logic               dbiu_stb_ack_o,
  output logic               dbiu_d_ack_o,
  input  logic [PLEN-1:0]    dbiu_adri_i,
  output logic [PLEN-1:0]    dbiu_adro_o,
  input  biu_pkg::biu_size_t dbiu_size_i,
  input  biu_pkg::biu_type_t dbiu_type_i,
  input  logic               dbiu_we_i,
  input  biu_pkg::data_t     dbiu_d_i,
  output biu_pkg::data_t     dbiu_q_o,
  output logic               dbiu_ack_o,
  output logic               dbiu_err_o,

  // external wishbone master
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output logic [PLEN-1:0]    wb_adr_o,
  output biu_pkg::data_t     wb_dat_o,
  output biu_pkg::sel_t      wb_sel_o,
  output biu_pkg::cti_t      wb_cti_o,
  output biu_pkg::bte_t      wb_bte_o,
  input  biu_pkg::data_t     wb_dat_i,
  input  logic               wb_ack_i,
  input  logic               wb_err_i
);

  import biu_pkg::*;

  // bridge to arbiter links, i for fetch, d for load/store
  logic            iwb_cyc, iwb_stb, iwb_we, iwb_ack, iwb_err;
  logic            dwb_cyc, dwb_stb, dwb_we, dwb_ack, dwb_err;
  logic [PLEN-1:0] iwb_adr, dwb_adr;
  data_t           iwb_dat_w, iwb_dat_r;   // write out, read back
  data_t           dwb_dat_w, dwb_dat_r;
  sel_t            iwb_sel, dwb_sel;
  cti_t            iwb_cti, dwb_cti;
  bte_t            iwb_bte, dwb_bte;

  biu2wb_bridge #(.PLEN(PLEN)) ibridge0 (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (ibiu_stb_i),
    .biu_stb_ack_o (ibiu_stb_ack_o),
    .biu_d_ack_o   (ibiu_d_ack_o),
    .biu_adri_i    (ibiu_adri_i),
    .biu_adro_o    (ibiu_adro_o),
    .biu_size_i    (ibiu_size_i),
    .biu_type_i    (ibiu_type_i),
    .biu_we_i      (ibiu_we_i),
    .biu_d_i       (ibiu_d_i),
    .biu_q_o       (ibiu_q_o),
    .biu_ack_o     (ibiu_ack_o),
    .biu_err_o     (ibiu_err_o),
    .wb_cyc_o      (iwb_cyc),
    .wb_stb_o      (iwb_stb),
    .wb_we_o       (iwb_we),
    .wb_adr_o      (iwb_adr),
    .wb_dat_o      (iwb_dat_w),
    .wb_sel_o      (iwb_sel),
    .wb_cti_o      (iwb_cti),
    .wb_bte_o      (iwb_bte),
    .wb_dat_i      (iwb_dat_r),
    .wb_ack_i      (iwb_ack),
    .wb_err_i      (iwb_err)
  );

  biu2wb_bridge #(.PLEN(PLEN)) dbridge0 (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (dbiu_stb_i),
    .biu_stb_ack_o (dbiu_stb_ack_o),
    .biu_d_ack_o   (dbiu_d_ack_o),
    .biu_adri_i    (dbiu_adri_i),
    .biu_adro_o    (dbiu_adro_o),
    .biu_size_i    (dbiu_size_i),
    .biu_type_i    (dbiu_type_i),
    .biu_we_i      (dbiu_we_i),
    .biu_d_i       (dbiu_d_i),
    .biu_q_o       (dbiu_q_o),
    .biu_ack_o     (dbiu_ack_o),
    .biu_err_o     (dbiu_err_o),
    .wb_cyc_o      (dwb_cyc),
    .wb_stb_o      (dwb_stb),
    .wb_we_o       (dwb_we),
    .wb_adr_o      (dwb_adr),
    .wb_dat_o      (dwb_dat_w),
    .wb_sel_o      (dwb_sel),
    .wb_cti_o      (dwb_cti),
    .wb_bte_o      (dwb_bte),
    .wb_dat_i      (dwb_dat_r),
    .wb_ack_i      (dwb_ack),
    .wb_err_i      (dwb_err)
  );

  // fetch on m0 so it wins the first contention
  wb_master_arbiter #(.PLEN(PLEN)) arb0 (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .m0_cyc_i (iwb_cyc),
    .m0_stb_i (iwb_stb),
    .m0_we_i  (iwb_we),
    .m0_adr_i (iwb_adr),
    .m0_dat_i (iwb_dat_w),
    .m0_sel_i (iwb_sel),
    .m0_cti_i (iwb_cti),
    .m0_bte_i (iwb_bte),
    .m0_ack_o (iwb_ack),
    .m0_err_o (iwb_err),
    .m0_dat_o (iwb_dat_r),
    .m1_cyc_i (dwb_cyc),
    .m1_stb_i (dwb_stb),
    .m1_we_i  (dwb_we),
    .m1_adr_i (dwb_adr),
    .m1_dat_i (dwb_dat_w),
    .m1_sel_i (dwb_sel),
    .m1_cti_i (dwb_cti),
    .m1_bte_i (dwb_bte),
    .m1_ack_o (dwb_ack),
    .m1_err_o (dwb_err),
    .m1_dat_o (dwb_dat_r),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_sel_o (wb_sel_o),
    .wb_cti_o (wb_cti_o),
    .wb_bte_o (wb_bte_o),
    .wb_dat_i (wb_dat_i),
    .wb_ack_i (wb_ack_i),
    .wb_err_i (wb_err_i)
  );

endmodule

// ==== build.f ====
biu_pkg.sv
biu2wb_bridge.sv
wb_master_arbiter.sv
biu_wb_top.sv
tb_biu_wb_assertions.sv
tb_biu_wb.sv

// ==== tb_biu_wb.sv ====
//////////////////////////////////////////////////
// testbench for biu_wb_top, patterns from a file and
// a wishbone memory with random wait states
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_biu_wb;

  localparam int TMO = 200;            // cycles per wait

  logic HCLK = 1'b0;
  logic HRESETn;
  // per port signals, index 0 fetch, 1 load/store
  logic [1:0]       stb, stb_ack, d_ack, we, ack, err;
  logic [1:0][31:0] adri, adro, d, q;
  logic [1:0][2:0]  size, btype;
  // external bus and memory model
  logic             wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [31:0]      wb_adr, wb_dat_o, wb_dat_i;
  logic [3:0]       wb_sel;
  logic [2:0]       wb_cti;
  logic [1:0]       wb_bte;
  logic [31:0]      mem [1024];        // what the slave holds
  logic [31:0]      ref_mem [1024];    // what it should hold
  logic [31:0]      pat [192];
  logic [31:0]      lcg_state = 32'h5d6457f6;
  logic [31:0]      rnd;
  logic [1:0]       wait_left;
  logic             busy;
  time              t_first [2];
  time              t_last [2];
  int               last_served;       // port granted last

  always #4 HCLK = ~HCLK;

  biu_wb_top #(.PLEN(32)) dut0 (
    .HCLK(HCLK), .HRESETn(HRESETn),
    .ibiu_stb_i(stb[0]), .ibiu_stb_ack_o(stb_ack[0]), .ibiu_d_ack_o(d_ack[0]),
    .ibiu_adri_i(adri[0]), .ibiu_adro_o(adro[0]), .ibiu_size_i(size[0]),
    .ibiu_type_i(btype[0]), .ibiu_we_i(we[0]), .ibiu_d_i(d[0]), .ibiu_q_o(q[0]),
    .ibiu_ack_o(ack[0]), .ibiu_err_o(err[0]),
    .dbiu_stb_i(stb[1]), .dbiu_stb_ack_o(stb_ack[1]), .dbiu_d_ack_o(d_ack[1]),
    .dbiu_adri_i(adri[1]), .dbiu_adro_o(adro[1]), .dbiu_size_i(size[1]),
    .dbiu_type_i(btype[1]), .dbiu_we_i(we[1]), .dbiu_d_i(d[1]), .dbiu_q_o(q[1]),
    .dbiu_ack_o(ack[1]), .dbiu_err_o(err[1]),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_o), .wb_sel_o(wb_sel), .wb_cti_o(wb_cti), .wb_bte_o(wb_bte),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack), .wb_err_i(wb_err)
  );

  bind wb_master_arbiter tb_biu_wb_assertions #(.PLEN(PLEN)) arb_sva0 (
    .HCLK(HCLK), .HRESETn(HRESETn), .wb_cyc(wb_cyc_o), .wb_stb(wb_stb_o),
    .wb_adr(wb_adr_o), .wb_ack(wb_ack_i), .wb_err(wb_err_i), .gnt(gnt)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] fill_word(logic [31:0] a);
    return a ^ {a[15:0], a[15:0]} ^ 32'h5a3c_0000;   // every address bit counts
  endfunction

  function automatic int beats_of(logic [2:0] t);
    case (t)
      3'd2, 3'd3: return 4;
      3'd4, 3'd5: return 8;
      3'd6, 3'd7: return 16;
      default:    return 1;      // single and plain incr
    endcase
  endfunction

  function automatic logic [3:0] exp_sel(logic [2:0] sz, logic [1:0] lo);
    case (sz)
      3'd0:    return 4'b0001 << lo;
      3'd1:    return lo[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [1:0] exp_bte(logic [2:0] t);
    case (t)
      3'd2:    return 2'b01;
      3'd4:    return 2'b10;
      3'd6:    return 2'b11;
      default: return 2'b00;
    endcase
  endfunction

  // word address plus 4, wrap bursts stay inside n*4 bytes
  function automatic logic [31:0] step_addr(logic [31:0] a, int n, logic wrap);
    logic [31:0] aw;
    logic [31:0] blk;
    aw  = (a & ~32'd3) + 32'd4;
    blk = 32'(n * 4);
    if (!wrap) return aw;
    return (a & ~(blk - 32'd1)) | (aw & (blk - 32'd1));
  endfunction

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act)
      fail_now($sformatf("mismatch %s expected %08h actual %08h", name, exp, act));
  endtask

  // wait for ack or err on one port, called at negedge plus 1
  task automatic wait_beat(int p, string tag);
    int tmo;
    tmo = 0;
    while (!(ack[p] || err[p])) begin
      tmo++;
      if (tmo > TMO)
        fail_now($sformatf("%s: biu_ack_o or biu_err_o never came on port %0d", tag, p));
      @(negedge HCLK);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // one biu transfer on one port, from a falling edge
  //////////////////////////////////////////////////

  task automatic run_transfer(int p, logic wr, logic [2:0] typ, logic [2:0] sz,
                              logic [31:0] adr, logic [31:0] seed, string tag);
    int          n;
    int          tmo;
    int          idx;
    logic        exp_err;
    logic [31:0] a;
    logic [31:0] mask;
    logic [3:0]  sel_e;
    logic [2:0]  cti_e;
    n       = beats_of(typ);
    exp_err = (adr[31:28] == 4'hF);   // slave error region
    a       = adr;
    stb[p]  = 1'b1;
    adri[p] = adr;
    size[p] = sz;
    btype[p] = typ;
    we[p]   = wr;
    d[p]    = seed;
    #1;
    tmo = 0;
    while (!stb_ack[p]) begin
      tmo++;
      if (tmo > TMO) fail_now($sformatf("%s: biu_stb_ack_o never came on port %0d", tag, p));
      @(negedge HCLK);
      #1;
    end
    @(negedge HCLK);
    stb[p] = 1'b0;
    #1;
    for (int k = 0; k < n; k++) begin
      wait_beat(p, tag);
      if (k == 0) t_first[p] = $time;
      t_last[p] = $time;
      check_value({tag, " err"}, 32'(exp_err), 32'(err[p]));
      if (err[p]) break;
      // bus belongs to this port during its beat
      sel_e = exp_sel(sz, a[1:0]);
      cti_e = (n == 1) ? 3'b000 : ((k == n - 1) ? 3'b111 : 3'b010);
      check_value($sformatf("%s beat %0d adro", tag, k), a, adro[p]);
      check_value($sformatf("%s beat %0d wb_adr", tag, k), a, wb_adr);
      check_value($sformatf("%s beat %0d sel", tag, k), 32'(sel_e), 32'(wb_sel));
      check_value($sformatf("%s beat %0d cti", tag, k), 32'(cti_e), 32'(wb_cti));
      check_value($sformatf("%s beat %0d bte", tag, k), 32'(exp_bte(typ)), 32'(wb_bte));
      check_value($sformatf("%s beat %0d we", tag, k), 32'(wr), 32'(wb_we));
      check_value($sformatf("%s beat %0d d_ack", tag, k), 32'(wr), 32'(d_ack[p]));
      check_value($sformatf("%s beat %0d other ack", tag, k), 32'd0, 32'(ack[1 - p]));
      idx = int'(a[11:2]);
      if (wr) begin
        check_value($sformatf("%s beat %0d wdata", tag, k), seed + 32'(k), wb_dat_o);
        mask = {{8{sel_e[3]}}, {8{sel_e[2]}}, {8{sel_e[1]}}, {8{sel_e[0]}}};
        ref_mem[idx] = (ref_mem[idx] & ~mask) | ((seed + 32'(k)) & mask);
      end else begin
        check_value($sformatf("%s beat %0d rdata", tag, k), ref_mem[idx], q[p]);
      end
      a = step_addr(a, n, (typ == 3'd2) || (typ == 3'd4) || (typ == 3'd6));
      @(negedge HCLK);
      if (wr) d[p] = seed + 32'(k) + 32'd1;   // next beat after d_ack
      #1;
    end
    // aborted burst stays quiet, past one gap and the longest wait
    if (exp_err) begin
      repeat (6) begin
        @(negedge HCLK);
        #1;
        check_value({tag, " ack after err"}, 32'd0, 32'(ack[p]));
        check_value({tag, " second err"}, 32'd0, 32'(err[p]));
      end
    end
  endtask

  //////////////////////////////////////////////////
  // memory model, 0 to 3 wait states per beat
  //////////////////////////////////////////////////

  always @(negedge HCLK) begin
    if (HRESETn) begin
      if (wb_ack || wb_err) begin
        wb_ack = 1'b0;                 // one cycle response
        wb_err = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!busy) begin
          rnd       = lcg_next();
          wait_left = rnd[17:16];
          busy      = 1'b1;
        end
        if (wait_left == 2'd0) begin
          busy = 1'b0;
          if (wb_adr[31:28] == 4'hF) begin
            wb_err = 1'b1;
          end else begin
            if (wb_we) begin
              for (int b = 0; b < 4; b++)
                if (wb_sel[b]) mem[wb_adr[11:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
            end else begin
              wb_dat_i = mem[wb_adr[11:2]];
            end
            wb_ack = 1'b1;
          end
        end else begin
          wait_left = wait_left - 2'd1;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int          i;
    int          b;
    int          port;
    int          w;
    string       tag;
    HRESETn = 1'b0;
    stb = '0;
    we = '0;
    adri = '0;
    d = '0;
    size = '0;
    btype = '0;
    wb_ack = 1'b0;
    wb_err = 1'b0;
    wb_dat_i = '0;
    busy = 1'b0;
    wait_left = '0;
    last_served = 1;                   // fetch port wins first
    for (int k = 0; k < 1024; k++) begin
      mem[k]     = fill_word(32'(k * 4));
      ref_mem[k] = fill_word(32'(k * 4));
    end
    $readmemh("biu_patterns.txt", pat);
    repeat (5) @(negedge HCLK);
    HRESETn = 1'b1;
    #1;
    // quiet after reset until a strobe
    check_value("reset stb_ack", 32'd0, 32'(stb_ack));
    check_value("reset d_ack", 32'd0, 32'(d_ack));
    check_value("reset ack", 32'd0, 32'(ack));
    check_value("reset err", 32'd0, 32'(err));
    check_value("reset wb_we", 32'd0, 32'(wb_we));
    repeat (4) begin
      check_value("reset wb_cyc", 32'd0, 32'(wb_cyc));
      check_value("reset wb_stb", 32'd0, 32'(wb_stb));
      @(negedge HCLK);
      #1;
    end
    i = 0;
    while (pat[i * 6] != 32'hF) begin
      b    = i * 6;
      port = int'(pat[b]);
      tag  = $sformatf("pattern %0d", i);
      @(negedge HCLK);
      if (port == 2) begin
        // same cycle strobe on both ports
        fork
          run_transfer(0, pat[b+1][0], pat[b+2][2:0], pat[b+3][2:0],
                       pat[b+4], pat[b+5], {tag, " fetch"});
          run_transfer(1, pat[b+1][0], pat[b+2][2:0], pat[b+3][2:0],
                       pat[b+4] + 32'h100, pat[b+5] + 32'h100, {tag, " data"});
        join
        w = 1 - last_served;
        check_value({tag, " grant order"}, 32'd1, 32'(t_last[w] < t_first[1 - w]));
        last_served = 1 - w;
      end else begin
        run_transfer(port, pat[b+1][0], pat[b+2][2:0], pat[b+3][2:0],
                     pat[b+4], pat[b+5], tag);
        last_served = port;
      end
      i++;
    end
    repeat (3) @(negedge HCLK);
    if (dut0.arb0.arb_sva0.fail_cnt != 0) begin
      $display("protocol assertions failed %0d times", dut0.arb0.arb_sva0.fail_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== tb_biu_wb_assertions.sv ====
//////////////////////////////////////////////////
// wishbone protocol checks, bound into the arbiter
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_biu_wb_assertions #(
  parameter int PLEN = 32
) (
  input logic            HCLK,
  input logic            HRESETn,
  input logic            wb_cyc,
  input logic            wb_stb,
  input logic [PLEN-1:0] wb_adr,
  input logic            wb_ack,
  input logic            wb_err,
  input logic [1:0]      gnt
);

  int unsigned fail_cnt = 0;   // read by the testbench at the end

  // no strobe outside a cycle
  stb_in_cyc: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wb_stb |-> wb_cyc)
    else begin $error("stb high without cyc"); fail_cnt++; end

  // address held until the slave answers
  adr_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (wb_stb && !wb_ack && !wb_err) |=> $stable(wb_adr))
    else begin $error("address moved during a waiting beat"); fail_cnt++; end

  // ownership fixed for the whole cycle
  gnt_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (wb_cyc && $past(wb_cyc)) |-> $stable(gnt))
    else begin $error("grant changed inside a cycle"); fail_cnt++; end

endmodule

// ==== wb_master_arbiter.sv ====
//////////////////////////////////////////////////
// shares one wishbone bus between two masters,
// alternating priority, grant held per cycle
//////////////////////////////////////////////////
`timescale 1ns/1ps

module wb_master_arbiter #(
  parameter int PLEN = 32
) (
  input  logic            HCLK,
  input  logic            HRESETn,

  // master 0, instruction bridge
  input  logic            m0_cyc_i,
  input  logic            m0_stb_i,
  input  logic            m0_we_i,
  input  logic [PLEN-1:0] m0_adr_i,
  input  biu_pkg::data_t  m0_dat_i,
  input  biu_pkg::sel_t   m0_sel_i,
  input  biu_pkg::cti_t   m0_cti_i,
  input  biu_pkg::bte_t   m0_bte_i,
  output logic            m0_ack_o,
  output logic            m0_err_o,
  output biu_pkg::data_t  m0_dat_o,

  // master 1, data bridge
  input  logic            m1_cyc_i,
  input  logic            m1_stb_i,
  input  logic            m1_we_i,
  input  logic [PLEN-1:0] m1_adr_i,
  input  biu_pkg::data_t  m1_dat_i,
  input  biu_pkg::sel_t   m1_sel_i,
  input  biu_pkg::cti_t   m1_cti_i,
  input  biu_pkg::bte_t   m1_bte_i,
  output logic            m1_ack_o,
  output logic            m1_err_o,
  output biu_pkg::data_t  m1_dat_o,

  // shared bus
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output logic            wb_we_o,
  output logic [PLEN-1:0] wb_adr_o,
  output biu_pkg::data_t  wb_dat_o,
  output biu_pkg::sel_t   wb_sel_o,
  output biu_pkg::cti_t   wb_cti_o,
  output biu_pkg::bte_t   wb_bte_o,
  input  biu_pkg::data_t  wb_dat_i,
  input  logic            wb_ack_i,
  input  logic            wb_err_i
);

  import biu_pkg::*;

  logic [1:0] gnt;       // {m1, m0}, 00 while the bus is free
  logic       last_m1;   // m1 won the last grant
  logic       pick_m1;   // winner if granted now
  logic       own_cyc;   // owner still in its cycle

  // contention goes to the port not served last
  always_comb begin
    if (m0_cyc_i && m1_cyc_i) pick_m1 = ~last_m1;
    else                      pick_m1 = m1_cyc_i;
  end

  assign own_cyc = gnt[1] ? m1_cyc_i : m0_cyc_i;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      gnt     <= 2'b00;
      last_m1 <= 1'b1;   // so instruction port goes first
    end else if (gnt == 2'b00) begin
      if (m0_cyc_i || m1_cyc_i) begin
        gnt     <= pick_m1 ? 2'b10 : 2'b01;
        last_m1 <= pick_m1;
      end
    end else if (!own_cyc) begin
      gnt <= 2'b00;      // owner dropped cyc
    end
  end

  //////////////////////////////////////////////////
  // request path, owner to shared bus
  //////////////////////////////////////////////////

  always_comb begin
    wb_cyc_o = 1'b0;
    wb_stb_o = 1'b0;
    wb_we_o  = 1'b0;
    wb_adr_o = '0;
    wb_dat_o = '0;
    wb_sel_o = '0;
    wb_cti_o = '0;
    wb_bte_o = '0;
    if (gnt[0]) begin
      wb_cyc_o = m0_cyc_i;
      wb_stb_o = m0_stb_i;
      wb_we_o  = m0_we_i;
      wb_adr_o = m0_adr_i;
      wb_dat_o = m0_dat_i;
      wb_sel_o = m0_sel_i;
      wb_cti_o = m0_cti_i;
      wb_bte_o = m0_bte_i;
    end else if (gnt[1]) begin
      wb_cyc_o = m1_cyc_i;
      wb_stb_o = m1_stb_i;
      wb_we_o  = m1_we_i;
      wb_adr_o = m1_adr_i;
      wb_dat_o = m1_dat_i;
      wb_sel_o = m1_sel_i;
      wb_cti_o = m1_cti_i;
      wb_bte_o = m1_bte_i;
    end
  end

  // responses reach the owner only
  assign m0_ack_o = gnt[0] & wb_ack_i;
  assign m0_err_o = gnt[0] & wb_err_i;
  assign m0_dat_o = gnt[0] ? wb_dat_i : '0;
  assign m1_ack_o = gnt[1] & wb_ack_i;
  assign m1_err_o = gnt[1] & wb_err_i;
  assign m1_dat_o = gnt[1] ? wb_dat_i : '0;

endmodule
